// File: rtl/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

  // One data or address word
  typedef logic [31:0] word_t;

  // One strobe bit per byte lane
  typedef logic [3:0] strb_t;

  // Memory word seen as bytes or as halfwords
  // Lane 0 is the least significant byte
  typedef union packed {
    word_t            word;
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } mem_word_u;

  // Source of the value written back to rd
  typedef enum logic [1:0] {
    RES_ALU = 2'b00,
    RES_LD  = 2'b01,
    RES_PC4 = 2'b10,
    RES_TGT = 2'b11
  } res_src_t;

  // Trap cause carried down the pipeline
  typedef enum logic [1:0] {
    TRAP_NONE          = 2'b00,
    TRAP_ILLEGAL       = 2'b01,
    TRAP_ECALL         = 2'b10,
    TRAP_LDST_MISALIGN = 2'b11
  } trap_code_t;

  // Load and store funct3 encodings
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // Access size, low two bits of funct3
  localparam logic [1:0] SIZE_BYTE = 2'b00;
  localparam logic [1:0] SIZE_HALF = 2'b01;
  localparam logic [1:0] SIZE_WORD = 2'b10;

endpackage

`default_nettype wire

// File: rtl/mem_store_format.sv
`timescale 1ns/1ps
`default_nettype none

module mem_store_format (
  input  logic                 mem_write,
  input  logic [2:0]           funct3,
  input  logic [1:0]           addr_low,
  input  mem_stage_pkg::word_t store_data,
  output mem_stage_pkg::word_t wdata,
  output mem_stage_pkg::strb_t wstrb
);

  // Size field of the store
  logic [1:0] size;

  // Raw store value and its lane-replicated copy
  mem_stage_pkg::mem_word_u src;
  mem_stage_pkg::mem_word_u rep;

  // Strobes before the write gate
  mem_stage_pkg::strb_t strb_raw;

  assign size = funct3[1:0];

  always_comb begin
    src.word = store_data;
    rep.word = src.word;
    strb_raw = 4'b1111;
    case (size)
      mem_stage_pkg::SIZE_BYTE: begin
        // Low byte copied into every lane
        rep.bytes[0] = src.bytes[0];
        rep.bytes[1] = src.bytes[0];
        rep.bytes[2] = src.bytes[0];
        rep.bytes[3] = src.bytes[0];
        strb_raw     = 4'b0001 << addr_low;
      end
      mem_stage_pkg::SIZE_HALF: begin
        // Low half copied into both halves
        rep.halves[0] = src.halves[0];
        rep.halves[1] = src.halves[0];
        // Upper or lower half selected by address bit 1
        strb_raw      = addr_low[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        // Full word, all lanes written
        rep.word = src.word;
        strb_raw = 4'b1111;
      end
    endcase
  end

  assign wdata = rep.word;

  // No lanes enabled unless a store is requested
  assign wstrb = mem_write ? strb_raw : '0;

endmodule

`default_nettype wire

// File: rtl/mem_align_check.sv
`timescale 1ns/1ps
`default_nettype none

module mem_align_check (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       mem_read,
  input  logic       mem_write,
  input  logic [2:0] funct3,
  input  logic [1:0] addr_low,
  input  logic       trap_in,
  output logic       misalign,
  output logic       trap_any,
  output logic       dmem_ren,
  output logic       dmem_we
);

  // Only a real access can be misaligned
  always_comb begin
    misalign = 1'b0;
    if (mem_read || mem_write) begin
      case (funct3[1:0])
        // Bytes are always aligned
        mem_stage_pkg::SIZE_BYTE: misalign = 1'b0;
        // Halfword needs an even address
        mem_stage_pkg::SIZE_HALF: misalign = addr_low[0];
        // Word needs both low bits clear
        mem_stage_pkg::SIZE_WORD: misalign = |addr_low;
        default:                  misalign = 1'b0;
      endcase
    end
  end

  // New fault or a trap raised earlier in the pipe
  assign trap_any = trap_in | misalign;

  // A trapping instruction must not touch memory
  assign dmem_ren = mem_read && !trap_any;
  assign dmem_we  = mem_write && !trap_any;

  // Misaligned half or word address never reaches the data memory
  a_no_access_on_misalign : assert property (
    @(posedge clk) disable iff (!rst_n)
    ((funct3[1:0] == mem_stage_pkg::SIZE_HALF && addr_low[0]) ||
     (funct3[1:0] == mem_stage_pkg::SIZE_WORD && addr_low != 2'b00))
    |-> !(dmem_ren || dmem_we)
  );

endmodule

`default_nettype wire

// File: rtl/mem_load_result.sv
`timescale 1ns/1ps
`default_nettype none

module mem_load_result (
  input  logic [2:0]              funct3,
  input  logic [1:0]              addr_low,
  input  mem_stage_pkg::word_t    rdata,
  input  mem_stage_pkg::res_src_t res_src,
  input  mem_stage_pkg::word_t    alu_result,
  input  mem_stage_pkg::word_t    pc_plus4,
  input  mem_stage_pkg::word_t    jb_target,
  output mem_stage_pkg::word_t    load_data,
  output mem_stage_pkg::word_t    result
);

  // Returned word with byte and half views
  mem_stage_pkg::mem_word_u rword;

  // Lane picked by the address offset
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  assign rword.word = rdata;

  // Byte lane from both offset bits
  assign sel_byte = rword.bytes[addr_low];

  // Half lane from address bit 1 only
  assign sel_half = rword.halves[addr_low[1]];

  // Extension by load kind
  always_comb begin
    case (funct3)
      mem_stage_pkg::F3_B: begin
        load_data = {{24{sel_byte[7]}}, sel_byte};
      end
      mem_stage_pkg::F3_H: begin
        load_data = {{16{sel_half[15]}}, sel_half};
      end
      mem_stage_pkg::F3_BU: begin
        load_data = {24'h000000, sel_byte};
      end
      mem_stage_pkg::F3_HU: begin
        load_data = {16'h0000, sel_half};
      end
      mem_stage_pkg::F3_W: begin
        load_data = rword.word;
      end
      default: begin
        // Unused codes behave as a word load
        load_data = rword.word;
      end
    endcase
  end

  // Forwarding value of this stage
  // Load results go out on load_data instead
  always_comb begin
    case (res_src)
      mem_stage_pkg::RES_PC4: result = pc_plus4;
      mem_stage_pkg::RES_TGT: result = jb_target;
      mem_stage_pkg::RES_ALU: result = alu_result;
      default:                result = alu_result;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/mem_wb_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg #(
  parameter int PIPELINED = 1
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stall,
  input  logic                      op_active,
  input  logic                      valid_in,
  input  logic                      reg_write_in,
  input  mem_stage_pkg::res_src_t   res_src_in,
  input  logic [4:0]                rd_in,
  input  mem_stage_pkg::word_t      alu_result_in,
  input  mem_stage_pkg::word_t      load_data_in,
  input  mem_stage_pkg::word_t      pc_plus4_in,
  input  mem_stage_pkg::word_t      jb_target_in,
  input  logic                      trap_any,
  input  logic                      misalign,
  input  mem_stage_pkg::trap_code_t trap_code_in,
  output logic                      valid_wb,
  output logic                      reg_write_wb,
  output mem_stage_pkg::res_src_t   res_src_wb,
  output logic [4:0]                rd_wb,
  output mem_stage_pkg::word_t      alu_result_wb,
  output mem_stage_pkg::word_t      load_data_wb,
  output mem_stage_pkg::word_t      pc_plus4_wb,
  output mem_stage_pkg::word_t      jb_target_wb,
  output logic                      trap_wb,
  output mem_stage_pkg::trap_code_t trap_code_wb
);

  if (PIPELINED != 0) begin : g_registered
    // Misalign seen while a multi-cycle op holds the MEM instruction
    logic misalign_hold;
    // Any trap, including one remembered across the stall
    logic trap_all;

    assign trap_all = trap_any | misalign_hold;

    // Cleared once the MEM instruction advances
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        misalign_hold <= 1'b0;
      end else if (!stall) begin
        misalign_hold <= 1'b0;
      end else if (op_active) begin
        misalign_hold <= misalign_hold | misalign;
      end
    end

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_wb      <= 1'b0;
        reg_write_wb  <= 1'b0;
        res_src_wb    <= mem_stage_pkg::RES_ALU;
        rd_wb         <= '0;
        alu_result_wb <= '0;
        load_data_wb  <= '0;
        pc_plus4_wb   <= '0;
        jb_target_wb  <= '0;
        trap_wb       <= 1'b0;
        trap_code_wb  <= mem_stage_pkg::TRAP_NONE;
      end else if (!stall) begin
        valid_wb      <= valid_in;
        // Trapping instruction never writes rd
        reg_write_wb  <= reg_write_in && !trap_all;
        res_src_wb    <= res_src_in;
        rd_wb         <= rd_in;
        alu_result_wb <= alu_result_in;
        load_data_wb  <= load_data_in;
        pc_plus4_wb   <= pc_plus4_in;
        jb_target_wb  <= jb_target_in;
        trap_wb       <= trap_all;
        // Size fault overrides the incoming code
        trap_code_wb  <= (misalign | misalign_hold) ?
                         mem_stage_pkg::TRAP_LDST_MISALIGN : trap_code_in;
      end else if (op_active) begin
        // Held instruction retires only once
        valid_wb <= 1'b0;
      end
    end

    // Multi-cycle stall kills the retire slot at that edge
    a_stall_clears_valid : assert property (
      @(posedge clk) disable iff (!rst_n)
      (stall && op_active) |=> !valid_wb
    );

    // Plain stall freezes every writeback output
    a_stall_holds_wb : assert property (
      @(posedge clk) disable iff (!rst_n)
      (stall && !op_active) |=> $stable({valid_wb, reg_write_wb, res_src_wb, rd_wb,
                                         alu_result_wb, load_data_wb, pc_plus4_wb,
                                         jb_target_wb, trap_wb, trap_code_wb})
    );
  end else begin : g_passthrough
    // Writeback sees the MEM values in the same cycle
    assign valid_wb      = valid_in;
    assign reg_write_wb  = reg_write_in && !trap_any;
    assign res_src_wb    = res_src_in;
    assign rd_wb         = rd_in;
    assign alu_result_wb = alu_result_in;
    assign load_data_wb  = load_data_in;
    assign pc_plus4_wb   = pc_plus4_in;
    assign jb_target_wb  = jb_target_in;
    assign trap_wb       = trap_any;
    assign trap_code_wb  = misalign ? mem_stage_pkg::TRAP_LDST_MISALIGN : trap_code_in;
  end

endmodule

`default_nettype wire

// File: rtl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
  parameter int PIPELINED = 1
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // Hazard control
  input  logic                      mem_wb_stall,
  input  logic                      op_active,
  // From execute
  input  logic                      valid_mem,
  input  logic                      reg_write_mem,
  input  logic                      mem_read_mem,
  input  logic                      mem_write_mem,
  input  mem_stage_pkg::res_src_t   res_src_mem,
  input  logic [4:0]                rd_mem,
  input  logic [2:0]                funct3_mem,
  input  mem_stage_pkg::word_t      alu_result_mem,
  input  mem_stage_pkg::word_t      rs2_data_mem,
  input  mem_stage_pkg::word_t      pc_plus4_mem,
  input  mem_stage_pkg::word_t      jb_target_mem,
  input  logic                      trap_mem,
  input  mem_stage_pkg::trap_code_t trap_code_mem,
  // Data memory, read data returns in the same cycle
  output logic                      dmem_ren,
  output mem_stage_pkg::word_t      dmem_raddr,
  input  mem_stage_pkg::word_t      dmem_rdata,
  output logic                      dmem_we,
  output mem_stage_pkg::word_t      dmem_waddr,
  output mem_stage_pkg::word_t      dmem_wdata,
  output mem_stage_pkg::strb_t      dmem_wstrb,
  // To writeback
  output logic                      valid_wb,
  output logic                      reg_write_wb,
  output mem_stage_pkg::res_src_t   res_src_wb,
  output logic [4:0]                rd_wb,
  output mem_stage_pkg::word_t      alu_result_wb,
  output mem_stage_pkg::word_t      load_data_wb,
  output mem_stage_pkg::word_t      pc_plus4_wb,
  output mem_stage_pkg::word_t      jb_target_wb,
  output logic                      trap_wb,
  output mem_stage_pkg::trap_code_t trap_code_wb,
  // Forwarding
  output mem_stage_pkg::word_t      result_mem,
  output mem_stage_pkg::word_t      load_data_mem
);

  // Size fault of the current access
  logic misalign;
  // Size fault or incoming trap
  logic trap_any;

  // Word-aligned addresses, lanes chosen by strobes
  assign dmem_raddr = {alu_result_mem[31:2], 2'b00};
  assign dmem_waddr = {alu_result_mem[31:2], 2'b00};

  mem_store_format st_fmt_i (
    .mem_write  (mem_write_mem),
    .funct3     (funct3_mem),
    .addr_low   (alu_result_mem[1:0]),
    .store_data (rs2_data_mem),
    .wdata      (dmem_wdata),
    .wstrb      (dmem_wstrb)
  );

  mem_align_check align_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_read  (mem_read_mem),
    .mem_write (mem_write_mem),
    .funct3    (funct3_mem),
    .addr_low  (alu_result_mem[1:0]),
    .trap_in   (trap_mem),
    .misalign  (misalign),
    .trap_any  (trap_any),
    .dmem_ren  (dmem_ren),
    .dmem_we   (dmem_we)
  );

  mem_load_result ld_res_i (
    .funct3     (funct3_mem),
    .addr_low   (alu_result_mem[1:0]),
    .rdata      (dmem_rdata),
    .res_src    (res_src_mem),
    .alu_result (alu_result_mem),
    .pc_plus4   (pc_plus4_mem),
    .jb_target  (jb_target_mem),
    .load_data  (load_data_mem),
    .result     (result_mem)
  );

  mem_wb_reg #(
    .PIPELINED (PIPELINED)
  ) wb_reg_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (mem_wb_stall),
    .op_active     (op_active),
    .valid_in      (valid_mem),
    .reg_write_in  (reg_write_mem),
    .res_src_in    (res_src_mem),
    .rd_in         (rd_mem),
    .alu_result_in (alu_result_mem),
    .load_data_in  (load_data_mem),
    .pc_plus4_in   (pc_plus4_mem),
    .jb_target_in  (jb_target_mem),
    .trap_any      (trap_any),
    .misalign      (misalign),
    .trap_code_in  (trap_code_mem),
    .valid_wb      (valid_wb),
    .reg_write_wb  (reg_write_wb),
    .res_src_wb    (res_src_wb),
    .rd_wb         (rd_wb),
    .alu_result_wb (alu_result_wb),
    .load_data_wb  (load_data_wb),
    .pc_plus4_wb   (pc_plus4_wb),
    .jb_target_wb  (jb_target_wb),
    .trap_wb       (trap_wb),
    .trap_code_wb  (trap_code_wb)
  );

endmodule

`default_nettype wire

// File: include/mem_stage_model.svh
`ifndef MEM_STAGE_MODEL_SVH
`define MEM_STAGE_MODEL_SVH

// Expected strobes, zero without a write
function automatic logic [3:0] model_wstrb(logic wr, logic [2:0] f3, logic [1:0] a);
  logic [3:0] s;
  case (f3[1:0])
    mem_stage_pkg::SIZE_BYTE: s = 4'b0001 << a;
    mem_stage_pkg::SIZE_HALF: s = a[1] ? 4'b1100 : 4'b0011;
    default:                  s = 4'b1111;
  endcase
  return wr ? s : 4'b0000;
endfunction

// Expected write data, replicated per size
function automatic logic [31:0] model_wdata(logic [2:0] f3, logic [31:0] d);
  case (f3[1:0])
    mem_stage_pkg::SIZE_BYTE: return {4{d[7:0]}};
    mem_stage_pkg::SIZE_HALF: return {2{d[15:0]}};
    default:                  return d;
  endcase
endfunction

// Expected load value after extension
function automatic logic [31:0] model_load(logic [2:0] f3, logic [1:0] a, logic [31:0] r);
  logic [7:0]  b;
  logic [15:0] h;
  b = r[a*8 +: 8];
  h = r[a[1]*16 +: 16];
  case (f3)
    mem_stage_pkg::F3_B:  return {{24{b[7]}}, b};
    mem_stage_pkg::F3_H:  return {{16{h[15]}}, h};
    mem_stage_pkg::F3_BU: return {24'h000000, b};
    mem_stage_pkg::F3_HU: return {16'h0000, h};
    default:              return r;
  endcase
endfunction

// Size fault, only for a real access
function automatic logic model_misalign(logic rd, logic wr, logic [2:0] f3, logic [1:0] a);
  if (!(rd || wr)) return 1'b0;
  case (f3[1:0])
    mem_stage_pkg::SIZE_HALF: return a[0];
    mem_stage_pkg::SIZE_WORD: return |a;
    default:                  return 1'b0;
  endcase
endfunction

// Expected trap code at writeback
function automatic mem_stage_pkg::trap_code_t model_trap_code(logic mis,
                                                              mem_stage_pkg::trap_code_t c);
  return mis ? mem_stage_pkg::TRAP_LDST_MISALIGN : c;
endfunction

`endif

// File: tests/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

  `include "mem_stage_model.svh"

  localparam int NUM_CYCLES    = 2000;
  localparam int RESET_TIMEOUT = 20;

  logic clk;
  logic rst_n;
  logic mem_wb_stall, op_active;
  logic valid_mem, reg_write_mem, mem_read_mem, mem_write_mem;
  mem_stage_pkg::res_src_t res_src_mem;
  logic [4:0] rd_mem;
  logic [2:0] funct3_mem;
  mem_stage_pkg::word_t alu_result_mem, rs2_data_mem, pc_plus4_mem, jb_target_mem;
  logic trap_mem;
  mem_stage_pkg::trap_code_t trap_code_mem;
  logic dmem_ren, dmem_we;
  mem_stage_pkg::word_t dmem_raddr, dmem_rdata, dmem_waddr, dmem_wdata;
  mem_stage_pkg::strb_t dmem_wstrb;
  logic valid_wb, reg_write_wb, trap_wb;
  mem_stage_pkg::res_src_t res_src_wb;
  logic [4:0] rd_wb;
  mem_stage_pkg::word_t alu_result_wb, load_data_wb, pc_plus4_wb, jb_target_wb;
  mem_stage_pkg::trap_code_t trap_code_wb;
  mem_stage_pkg::word_t result_mem, load_data_mem;

  // Expected writeback state, stepped at every active edge
  logic exp_valid, exp_rw, exp_trap, exp_sticky;
  logic [1:0] exp_src;
  logic [4:0] exp_rd;
  logic [31:0] exp_alu, exp_ld, exp_pc4, exp_tgt;
  mem_stage_pkg::trap_code_t exp_code;

  integer seed = 32'h59d2_0b98;
  int error_count = 0;
  // Rough coverage counters
  int n_misalign = 0;
  int n_op_stall = 0;

  mem_stage #(.PIPELINED(1)) dut_i (.*);

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset low for three rising edges
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
  end

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      error_count++;
      $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
      $display("Simulation failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Forwarded value by result source
  function automatic logic [31:0] expected_forward(logic [1:0] src, logic [31:0] alu,
                                                   logic [31:0] pc4, logic [31:0] tgt);
    case (src)
      mem_stage_pkg::RES_PC4: return pc4;
      mem_stage_pkg::RES_TGT: return tgt;
      default:                return alu;
    endcase
  endfunction

  // Load funct3 from a 3-bit draw, all five kinds reachable
  function automatic logic [2:0] pick_funct3(logic [2:0] i);
    case (i)
      3'd0, 3'd5: return mem_stage_pkg::F3_B;
      3'd1:       return mem_stage_pkg::F3_H;
      3'd2, 3'd6: return mem_stage_pkg::F3_W;
      3'd3:       return mem_stage_pkg::F3_BU;
      default:    return mem_stage_pkg::F3_HU;
    endcase
  endfunction

  task automatic inspect_reset();
    compare_value("reset valid_wb", 1'b0, valid_wb);
    compare_value("reset reg_write_wb", 1'b0, reg_write_wb);
    compare_value("reset trap_wb", 1'b0, trap_wb);
    compare_value("reset trap_code_wb", mem_stage_pkg::TRAP_NONE, trap_code_wb);
    compare_value("reset alu_result_wb", 32'h0, alu_result_wb);
    compare_value("reset load_data_wb", 32'h0, load_data_wb);
  endtask

  // Inputs still hold their values from the edge just passed
  task automatic advance_model();
    logic mis;
    logic trap_all;
    mis = model_misalign(mem_read_mem, mem_write_mem, funct3_mem, alu_result_mem[1:0]);
    if (!mem_wb_stall) begin
      // Sticky flag joins the advancing instruction
      trap_all   = trap_mem | mis | exp_sticky;
      exp_valid  = valid_mem;
      exp_rw     = reg_write_mem && !trap_all;
      exp_src    = res_src_mem;
      exp_rd     = rd_mem;
      exp_alu    = alu_result_mem;
      exp_ld     = model_load(funct3_mem, alu_result_mem[1:0], dmem_rdata);
      exp_pc4    = pc_plus4_mem;
      exp_tgt    = jb_target_mem;
      exp_trap   = trap_all;
      exp_code   = model_trap_code(mis | exp_sticky, trap_code_mem);
      exp_sticky = 1'b0;
      if (mis) n_misalign++;
    end else if (op_active) begin
      // Held instruction must not retire twice
      exp_valid  = 1'b0;
      exp_sticky = exp_sticky | mis;
      n_op_stall++;
    end
  endtask

  task automatic audit_writeback();
    compare_value("wb valid", exp_valid, valid_wb);
    compare_value("wb reg_write", exp_rw, reg_write_wb);
    compare_value("wb res_src", exp_src, res_src_wb);
    compare_value("wb rd", exp_rd, rd_wb);
    compare_value("wb alu_result", exp_alu, alu_result_wb);
    compare_value("wb load_data", exp_ld, load_data_wb);
    compare_value("wb pc_plus4", exp_pc4, pc_plus4_wb);
    compare_value("wb jb_target", exp_tgt, jb_target_wb);
    compare_value("wb trap", exp_trap, trap_wb);
    compare_value("wb trap_code", exp_code, trap_code_wb);
  endtask

  // Zero-cycle outputs, sampled mid-cycle
  task automatic verify_mem_side();
    logic mis;
    logic trap_any;
    mis      = model_misalign(mem_read_mem, mem_write_mem, funct3_mem, alu_result_mem[1:0]);
    trap_any = trap_mem | mis;
    compare_value("dmem_ren", mem_read_mem && !trap_any, dmem_ren);
    compare_value("dmem_we", mem_write_mem && !trap_any, dmem_we);
    compare_value("dmem_raddr", {alu_result_mem[31:2], 2'b00}, dmem_raddr);
    compare_value("dmem_waddr", {alu_result_mem[31:2], 2'b00}, dmem_waddr);
    compare_value("dmem_wdata", model_wdata(funct3_mem, rs2_data_mem), dmem_wdata);
    compare_value("dmem_wstrb",
                  model_wstrb(mem_write_mem, funct3_mem, alu_result_mem[1:0]), dmem_wstrb);
    compare_value("load_data_mem",
                  model_load(funct3_mem, alu_result_mem[1:0], dmem_rdata), load_data_mem);
    compare_value("result_mem",
                  expected_forward(res_src_mem, alu_result_mem, pc_plus4_mem, jb_target_mem),
                  result_mem);
  endtask

  // New instruction only when the last edge let MEM advance
  task automatic drive_next();
    logic [31:0] r;
    logic [31:0] a;
    logic [1:0]  kind;
    if (!mem_wb_stall) begin
      r    = $random(seed);
      kind = r[1:0];
      // Half loads, a quarter stores, a quarter no access
      mem_read_mem  = (kind == 2'd0) || (kind == 2'd3);
      mem_write_mem = (kind == 2'd1);
      valid_mem     = (r[4:2] != 3'd0);
      reg_write_mem = r[5] && !mem_write_mem;
      if (mem_read_mem) res_src_mem = mem_stage_pkg::RES_LD;
      else res_src_mem = mem_stage_pkg::res_src_t'(r[7:6]);
      rd_mem = r[12:8];
      if (mem_read_mem) funct3_mem = pick_funct3(r[15:13]);
      else if (mem_write_mem) funct3_mem = {1'b0, (r[14:13] == 2'd3) ? 2'd2 : r[14:13]};
      else funct3_mem = r[15:13];
      a = $random(seed);
      // Mostly aligned, about one in eight keeps raw offset bits
      if (r[18:16] != 3'd0) begin
        if (funct3_mem[1:0] == mem_stage_pkg::SIZE_HALF) a[0] = 1'b0;
        if (funct3_mem[1:0] == mem_stage_pkg::SIZE_WORD) a[1:0] = 2'b00;
      end
      alu_result_mem = a;
      rs2_data_mem   = $random(seed);
      pc_plus4_mem   = $random(seed);
      jb_target_mem  = $random(seed);
      // Rare trap from an earlier stage
      trap_mem = (r[22:19] == 4'd0);
      if (!trap_mem) trap_code_mem = mem_stage_pkg::TRAP_NONE;
      else if (r[23]) trap_code_mem = mem_stage_pkg::TRAP_ECALL;
      else trap_code_mem = mem_stage_pkg::TRAP_ILLEGAL;
    end
    r = $random(seed);
    mem_wb_stall = (r[1:0] == 2'b00);
    op_active    = r[2];
    dmem_rdata   = $random(seed);
  endtask

  initial begin
    int cycles;
    int i;
    mem_wb_stall   = 1'b0;
    op_active      = 1'b0;
    valid_mem      = 1'b0;
    reg_write_mem  = 1'b0;
    mem_read_mem   = 1'b0;
    mem_write_mem  = 1'b0;
    res_src_mem    = mem_stage_pkg::RES_ALU;
    rd_mem         = '0;
    funct3_mem     = '0;
    alu_result_mem = '0;
    rs2_data_mem   = '0;
    pc_plus4_mem   = '0;
    jb_target_mem  = '0;
    trap_mem       = 1'b0;
    trap_code_mem  = mem_stage_pkg::TRAP_NONE;
    dmem_rdata     = '0;
    // Model starts from the reset values
    exp_valid  = 1'b0;
    exp_rw     = 1'b0;
    exp_trap   = 1'b0;
    exp_sticky = 1'b0;
    exp_src    = mem_stage_pkg::RES_ALU;
    exp_rd     = '0;
    exp_alu    = '0;
    exp_ld     = '0;
    exp_pc4    = '0;
    exp_tgt    = '0;
    exp_code   = mem_stage_pkg::TRAP_NONE;
    cycles     = 0;
    #1;
    while (!rst_n) begin
      if (cycles >= RESET_TIMEOUT) begin
        $display("Reset was not released after %0d cycles", cycles);
        $display("Simulation failed");
        $fatal(1, "Reset timeout");
      end else begin
        @(posedge clk);
        #1;
        if (!rst_n) inspect_reset();
        cycles++;
      end
    end
    // Each pass starts 1 ns after a rising edge
    for (i = 0; i < NUM_CYCLES; i++) begin
      advance_model();
      audit_writeback();
      #1;
      drive_next();
      #18;
      verify_mem_side();
      @(posedge clk);
      #1;
    end
    $display("Ran %0d cycles, %0d misaligned retires, %0d multi-cycle stalls",
             NUM_CYCLES, n_misalign, n_op_stall);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_stage.f
+incdir+include
rtl/mem_stage_pkg.sv
rtl/mem_store_format.sv
rtl/mem_align_check.sv
rtl/mem_load_result.sv
rtl/mem_wb_reg.sv
rtl/mem_stage.sv
tests/mem_stage_tb.sv
